// ==== list.f ====
+incdir+rtl
rtl/sensor_pkg.sv
rtl/spi_link_pkg.sv
rtl/sensor_capture.sv
rtl/sensor_snapshot.sv
rtl/packet_shifter.sv
rtl/spi_sensor_slave.sv
tests/spi_sensor_slave_props.sv
tests/tb_spi_sensor_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_spi_sensor_slave -o sim_tb

# Keep running past assertion errors so the testbench can print its own verdict
output=$(./obj_dir/sim_tb +verilator+error+limit+100 || true)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "RESULT: PASS"

// ==== tests/tb_spi_sensor_slave.sv ====
module tb_spi_sensor_slave
    import sensor_pkg::*;
    import spi_link_pkg::*;
();

    localparam int NUM_TRANS = 40;
    // 40 transactions of at most 18 bytes at 4 clk per bit is about 23000 clk,
    // idle gaps and input pulses add roughly 30 clk per transaction
    localparam int TIMEOUT_CYCLES = 30000;

    logic clk;
    logic cs_n;
    logic sck;
    logic initialized;
    logic error;
    logic quat_valid;
    logic gyro_valid;
    sample_t quat_w, quat_x, quat_y, quat_z;
    sample_t gyro_x, gyro_y, gyro_z;
    wire sdo;

    // Reference model, the sample set the master should see in the next packet
    sample_t model_quat_w = '0, model_quat_x = '0, model_quat_y = '0, model_quat_z = '0;
    sample_t model_gyro_x = '0, model_gyro_y = '0, model_gyro_z = '0;
    status_flags_t model_flags = '0;
    // Set by a valid pulse during idle time, cleared when a transaction ends
    logic quat_pending = 1'b0;
    logic gyro_pending = 1'b0;
    byte_t exp_q[$];

    logic [31:0] rng_state = 32'ha4479300;
    int byte_errors = 0;
    int flag_errors = 0;

    spi_sensor_slave dut_i (
        .clk(clk), .cs_n(cs_n), .sck(sck), .initialized(initialized), .error(error),
        .quat_valid(quat_valid), .gyro_valid(gyro_valid),
        .quat_w(quat_w), .quat_x(quat_x), .quat_y(quat_y), .quat_z(quat_z),
        .gyro_x(gyro_x), .gyro_y(gyro_y), .gyro_z(gyro_z), .sdo(sdo)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // New samples and levels every call, valid pulses only now and then
    task automatic drive_idle_inputs(input bit force_valid);
        logic [31:0] ctl;
        logic [31:0] r;
        ctl = next_random();
        @(posedge clk);
        #10;
        r = next_random();
        quat_w = r[31:16];
        quat_x = r[15:0];
        r = next_random();
        quat_y = r[31:16];
        quat_z = r[15:0];
        r = next_random();
        gyro_x = r[31:16];
        gyro_y = r[15:0];
        r = next_random();
        gyro_z = r[15:0];
        initialized = ctl[2] | ctl[5];
        error = ctl[3] & ctl[4];
        quat_valid = ctl[0] | force_valid;
        gyro_valid = ctl[1] | force_valid;
        quat_pending = quat_pending | quat_valid;
        gyro_pending = gyro_pending | gyro_valid;
        @(posedge clk);
        #10;
        quat_valid = 1'b0;
        gyro_valid = 1'b0;
    endtask

    // Inputs change and pulse mid transaction, none of it may reach the wire
    // The changed samples sit in bytes the shifter has not loaded yet
    task automatic disturb_inputs();
        logic [31:0] r;
        #10;
        r = next_random();
        quat_z = r[31:16];
        gyro_z = r[15:0];
        initialized = ~initialized;
        error = ~error;
        quat_valid = 1'b1;
        gyro_valid = 1'b1;
        @(posedge clk);
        #10;
        quat_valid = 1'b0;
        gyro_valid = 1'b0;
    endtask

    // Mode 0 master, samples sdo as sck rises, 2 clk high then 2 clk low
    task automatic shift_bits(input int count, output byte_t data);
        data = 8'h00;
        repeat (count) begin
            @(posedge clk);
            #10;
            data = {data[6:0], sdo};
            sck = 1'b1;
            @(posedge clk);
            @(posedge clk);
            #10;
            sck = 1'b0;
            @(posedge clk);
        end
    endtask

    // --------------------------------------------------
    // Model and checks
    // --------------------------------------------------

    task automatic push_sample(input sample_t s);
        exp_q.push_back(s[15:8]);
        exp_q.push_back(s[7:0]);
    endtask

    // Selection freezes the snapshot, so the model takes its values here
    task automatic commit_model();
        if (quat_pending) begin
            model_quat_w = quat_w;
            model_quat_x = quat_x;
            model_quat_y = quat_y;
            model_quat_z = quat_z;
        end
        if (gyro_pending) begin
            model_gyro_x = gyro_x;
            model_gyro_y = gyro_y;
            model_gyro_z = gyro_z;
        end
        model_flags.quat_valid = quat_pending;
        model_flags.gyro_valid = gyro_pending;
        model_flags.initialized = initialized;
        model_flags.error = error;
        exp_q.delete();
        exp_q.push_back(8'hAA);
        push_sample(model_quat_w);
        push_sample(model_quat_x);
        push_sample(model_quat_y);
        push_sample(model_quat_z);
        push_sample(model_gyro_x);
        push_sample(model_gyro_y);
        push_sample(model_gyro_z);
        exp_q.push_back({4'h0, model_flags});
        // Two bytes of the zero tail
        exp_q.push_back(8'h00);
        exp_q.push_back(8'h00);
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input byte_idx_t pos);
        if (got !== exp) begin
            byte_errors++;
            $display("Mismatch at %0t: byte %0d got %02h expected %02h", $time, pos, got, exp);
        end
    endtask

    task automatic check_flags(input status_flags_t got, input status_flags_t exp);
        if (got !== exp) begin
            flag_errors++;
            $display("Mismatch at %0t: byte 15 flags got %b expected %b", $time, got, exp);
        end
    endtask

    // Reads nbytes whole bytes, then part_bits more before cs_n goes high
    task automatic run_transaction(input byte_idx_t nbytes, input int part_bits,
                                   input bit disturb);
        byte_t got;
        byte_t exp;
        byte_idx_t pos;
        status_flags_t got_flags;
        @(posedge clk);
        #10;
        cs_n = 1'b0;
        commit_model();
        repeat (4) @(posedge clk);
        for (pos = 5'd0; pos < nbytes; pos++) begin
            shift_bits(8, got);
            exp = exp_q.pop_front();
            if (pos == 5'd15) begin
                got_flags = got[3:0];
                check_flags(got_flags, model_flags);
                check_byte({got[7:4], 4'h0}, 8'h00, pos);
            end else begin
                check_byte(got, exp, pos);
            end
            if (disturb && pos == 5'd1) begin
                disturb_inputs();
            end
        end
        if (part_bits > 0) begin
            shift_bits(part_bits, got);
            exp = exp_q.pop_front();
            check_byte(got, exp >> (8 - part_bits), pos);
        end
        @(posedge clk);
        #10;
        cs_n = 1'b1;
        quat_pending = 1'b0;
        gyro_pending = 1'b0;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        byte_idx_t nbytes;
        int part_bits;
        logic [31:0] r;
        cs_n = 1'b1;
        sck = 1'b0;
        initialized = 1'b0;
        error = 1'b0;
        quat_valid = 1'b0;
        gyro_valid = 1'b0;
        quat_w = '0;
        quat_x = '0;
        quat_y = '0;
        quat_z = '0;
        gyro_x = '0;
        gyro_y = '0;
        gyro_z = '0;
        // Reset of 2 clk with one sck pulse, the shifter loads the header on it
        @(posedge clk);
        #10;
        sck = 1'b1;
        @(posedge clk);
        #10;
        sck = 1'b0;
        for (int t = 0; t < NUM_TRANS; t++) begin
            r = next_random();
            // Give the latches time to clear after the previous cs_n rise
            repeat (3) @(posedge clk);
            drive_idle_inputs(t == 0);
            if (r[2]) begin
                drive_idle_inputs(1'b0);
            end
            repeat (5) @(posedge clk);
            nbytes = (t % 4 == 0) ? 5'd18 : 5'd16;
            part_bits = 0;
            if (t % 5 == 3) begin
                nbytes = 5'd3 + {3'b000, r[4:3]};
                part_bits = 4;
            end
            run_transaction(nbytes, part_bits, t % 3 == 1);
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d byte, %0d flags, %0d assertion", byte_errors, flag_errors,
                 dut_i.props_i.fail_count);
        if (byte_errors + flag_errors + dut_i.props_i.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clk cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tests/spi_sensor_slave_props.sv ====
module spi_sensor_slave_props
    import sensor_pkg::*;
    import spi_link_pkg::*;
(
    input logic          clk,
    input logic          cs_n,
    input logic          sdo,
    input shift_state_e  state,
    input status_flags_t snap_flags,
    input sample_t       snap_quat_w,
    input sample_t       snap_quat_x,
    input sample_t       snap_quat_y,
    input sample_t       snap_quat_z,
    input sample_t       snap_gyro_x,
    input sample_t       snap_gyro_y,
    input sample_t       snap_gyro_z
);

    // Number of failed assertions, read by the testbench at the end
    int fail_count = 0;

    // A selected slave always drives a defined level on sdo
    sdo_known_a: assert property (@(posedge clk) !cs_n |-> !$isunknown(sdo))
        else begin
            fail_count++;
            $error("sdo is unknown while cs_n is low");
        end

    // The registered select lags cs_n by one clk and the snapshot may take one
    // last idle update on that clk, so the freeze holds from the third selected clk
    snap_frozen_a: assert property (@(posedge clk)
        !cs_n && $past(!cs_n) && $past(!cs_n, 2) |->
        $stable({snap_flags, snap_quat_w, snap_quat_x, snap_quat_y, snap_quat_z,
                 snap_gyro_x, snap_gyro_y, snap_gyro_z}))
        else begin
            fail_count++;
            $error("snapshot changed while the bus was selected");
        end

    // Past byte 15 only zeros go out
    tail_zero_a: assert property (@(posedge clk) !cs_n && state == shift_tail |-> sdo == 1'b0)
        else begin
            fail_count++;
            $error("sdo is not zero in the tail state");
        end

endmodule

bind spi_sensor_slave spi_sensor_slave_props props_i (
    .clk(clk), .cs_n(cs_n), .sdo(sdo), .state(shifter_i.state),
    .snap_flags(snap_flags),
    .snap_quat_w(snap_quat_w), .snap_quat_x(snap_quat_x),
    .snap_quat_y(snap_quat_y), .snap_quat_z(snap_quat_z),
    .snap_gyro_x(snap_gyro_x), .snap_gyro_y(snap_gyro_y), .snap_gyro_z(snap_gyro_z)
);

// ==== rtl/spi_sensor_slave.sv ====
module spi_sensor_slave
    import sensor_pkg::*;
(
    input  logic    clk,
    input  logic    cs_n,
    input  logic    sck,
    input  logic    initialized,
    input  logic    error,
    input  logic    quat_valid,
    input  logic    gyro_valid,
    input  sample_t quat_w,
    input  sample_t quat_x,
    input  sample_t quat_y,
    input  sample_t quat_z,
    input  sample_t gyro_x,
    input  sample_t gyro_y,
    input  sample_t gyro_z,
    output logic    sdo
);

    sample_t cap_quat_w, cap_quat_x, cap_quat_y, cap_quat_z;
    sample_t cap_gyro_x, cap_gyro_y, cap_gyro_z;
    sample_t snap_quat_w, snap_quat_x, snap_quat_y, snap_quat_z;
    sample_t snap_gyro_x, snap_gyro_y, snap_gyro_z;
    status_flags_t snap_flags;
    logic sync_initialized;
    logic sync_error;
    logic quat_latched;
    logic gyro_latched;
    logic cs_sel;

    // --------------------------------------------------
    // clk domain
    // --------------------------------------------------

    sensor_capture capture_i (
        .clk(clk), .cs_n(cs_n), .initialized(initialized), .error(error),
        .quat_valid(quat_valid), .gyro_valid(gyro_valid),
        .quat_w(quat_w), .quat_x(quat_x), .quat_y(quat_y), .quat_z(quat_z),
        .gyro_x(gyro_x), .gyro_y(gyro_y), .gyro_z(gyro_z),
        .cap_quat_w(cap_quat_w), .cap_quat_x(cap_quat_x),
        .cap_quat_y(cap_quat_y), .cap_quat_z(cap_quat_z),
        .cap_gyro_x(cap_gyro_x), .cap_gyro_y(cap_gyro_y), .cap_gyro_z(cap_gyro_z),
        .sync_initialized(sync_initialized), .sync_error(sync_error),
        .quat_latched(quat_latched), .gyro_latched(gyro_latched), .cs_sel(cs_sel)
    );

    sensor_snapshot snapshot_i (
        .clk(clk), .cs_sel(cs_sel),
        .quat_latched(quat_latched), .gyro_latched(gyro_latched),
        .sync_initialized(sync_initialized), .sync_error(sync_error),
        .cap_quat_w(cap_quat_w), .cap_quat_x(cap_quat_x),
        .cap_quat_y(cap_quat_y), .cap_quat_z(cap_quat_z),
        .cap_gyro_x(cap_gyro_x), .cap_gyro_y(cap_gyro_y), .cap_gyro_z(cap_gyro_z),
        .snap_quat_w(snap_quat_w), .snap_quat_x(snap_quat_x),
        .snap_quat_y(snap_quat_y), .snap_quat_z(snap_quat_z),
        .snap_gyro_x(snap_gyro_x), .snap_gyro_y(snap_gyro_y),
        .snap_gyro_z(snap_gyro_z), .snap_flags(snap_flags)
    );

    // --------------------------------------------------
    // sck domain, reads the frozen snapshot
    // --------------------------------------------------

    packet_shifter shifter_i (
        .sck(sck), .cs_n(cs_n),
        .snap_quat_w(snap_quat_w), .snap_quat_x(snap_quat_x),
        .snap_quat_y(snap_quat_y), .snap_quat_z(snap_quat_z),
        .snap_gyro_x(snap_gyro_x), .snap_gyro_y(snap_gyro_y),
        .snap_gyro_z(snap_gyro_z), .snap_flags(snap_flags), .sdo(sdo)
    );

endmodule

// ==== rtl/packet_shifter.sv ====
`include "sensor_link_cfg.svh"

module packet_shifter
    import sensor_pkg::*;
    import spi_link_pkg::*;
(
    input  logic          sck,
    input  logic          cs_n,
    input  sample_t       snap_quat_w,
    input  sample_t       snap_quat_x,
    input  sample_t       snap_quat_y,
    input  sample_t       snap_quat_z,
    input  sample_t       snap_gyro_x,
    input  sample_t       snap_gyro_y,
    input  sample_t       snap_gyro_z,
    input  status_flags_t snap_flags,
    output logic          sdo
);

    packet_t      packet;
    byte_t        shift_reg;
    byte_t        next_byte;
    byte_idx_t    byte_idx;
    byte_idx_t    next_idx;
    bit_idx_t     bit_idx;
    shift_state_e state;

    // --------------------------------------------------
    // Packet assembly
    // --------------------------------------------------

    // Each sample goes out high byte first
    always_comb begin
        packet[0] = `SL_HEADER_BYTE;
        packet[1] = snap_quat_w[`SL_SAMPLE_W-1 -: 8];
        packet[2] = snap_quat_w[7:0];
        packet[3] = snap_quat_x[`SL_SAMPLE_W-1 -: 8];
        packet[4] = snap_quat_x[7:0];
        packet[5] = snap_quat_y[`SL_SAMPLE_W-1 -: 8];
        packet[6] = snap_quat_y[7:0];
        packet[7] = snap_quat_z[`SL_SAMPLE_W-1 -: 8];
        packet[8] = snap_quat_z[7:0];
        packet[9] = snap_gyro_x[`SL_SAMPLE_W-1 -: 8];
        packet[10] = snap_gyro_x[7:0];
        packet[11] = snap_gyro_y[`SL_SAMPLE_W-1 -: 8];
        packet[12] = snap_gyro_y[7:0];
        packet[13] = snap_gyro_z[`SL_SAMPLE_W-1 -: 8];
        packet[14] = snap_gyro_z[7:0];
        // Upper nibble of the flags byte is always zero
        packet[15] = {4'h0, snap_flags};
    end

    // Byte index saturates at 31 so a long read never wraps into the header
    assign next_idx = (byte_idx == 5'd31) ? byte_idx : byte_idx + 5'd1;
    assign next_byte = (next_idx < `SL_PACKET_BYTES) ? packet[next_idx[3:0]] : '0;

    // --------------------------------------------------
    // Shifter FSM, rising sck
    // --------------------------------------------------

    // Leaving shift_wait marks that the master has sampled the first bit
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            state <= shift_wait;
        end else begin
            case (state)
                shift_wait: state <= shift_active;
                shift_active: begin
                    if (byte_idx >= `SL_PACKET_BYTES) begin
                        state <= shift_tail;
                    end
                end
                default: state <= shift_tail;
            endcase
        end
    end

    // --------------------------------------------------
    // Shift register, falling sck
    // --------------------------------------------------

    // Deselect reloads the header, so its MSB is on sdo as soon as cs_n falls
    always_ff @(negedge sck or posedge cs_n) begin
        if (cs_n) begin
            shift_reg <= `SL_HEADER_BYTE;
            byte_idx <= '0;
            bit_idx <= '0;
        end else if (state != shift_wait) begin
            if (bit_idx == 3'd7) begin
                shift_reg <= next_byte;
                byte_idx <= next_idx;
                bit_idx <= '0;
            end else begin
                shift_reg <= {shift_reg[6:0], 1'b0};
                bit_idx <= bit_idx + 3'd1;
            end
        end
    end

    // Bus is shared, so release it when not selected
    assign sdo = cs_n ? 1'bz : shift_reg[7];

endmodule

// ==== rtl/sensor_snapshot.sv ====
module sensor_snapshot
    import sensor_pkg::*;
(
    input  logic          clk,
    input  logic          cs_sel,
    input  logic          quat_latched,
    input  logic          gyro_latched,
    input  logic          sync_initialized,
    input  logic          sync_error,
    input  sample_t       cap_quat_w,
    input  sample_t       cap_quat_x,
    input  sample_t       cap_quat_y,
    input  sample_t       cap_quat_z,
    input  sample_t       cap_gyro_x,
    input  sample_t       cap_gyro_y,
    input  sample_t       cap_gyro_z,
    output sample_t       snap_quat_w = '0,
    output sample_t       snap_quat_x = '0,
    output sample_t       snap_quat_y = '0,
    output sample_t       snap_quat_z = '0,
    output sample_t       snap_gyro_x = '0,
    output sample_t       snap_gyro_y = '0,
    output sample_t       snap_gyro_z = '0,
    output status_flags_t snap_flags = '0
);

    // --------------------------------------------------
    // Snapshot registers
    // --------------------------------------------------

    // While the bus is idle the snapshot tracks the newest valid samples
    // Once cs_sel goes high every field holds until the transaction ends,
    // which keeps the sck-domain shifter reading stable values
    always_ff @(posedge clk) begin
        if (!cs_sel) begin
            // A group without a pending valid pulse keeps its older values,
            // so the master never sees samples the sensor did not mark valid
            if (quat_latched) begin
                snap_quat_w <= cap_quat_w;
                snap_quat_x <= cap_quat_x;
                snap_quat_y <= cap_quat_y;
                snap_quat_z <= cap_quat_z;
            end
            if (gyro_latched) begin
                snap_gyro_x <= cap_gyro_x;
                snap_gyro_y <= cap_gyro_y;
                snap_gyro_z <= cap_gyro_z;
            end
            // Flags follow their sources on every idle clk
            snap_flags.quat_valid <= quat_latched;
            snap_flags.gyro_valid <= gyro_latched;
            snap_flags.initialized <= sync_initialized;
            snap_flags.error <= sync_error;
        end
    end

endmodule

// ==== rtl/sensor_capture.sv ====
`include "sensor_link_cfg.svh"

module sensor_capture
    import sensor_pkg::*;
(
    input  logic    clk,
    input  logic    cs_n,
    input  logic    initialized,
    input  logic    error,
    input  logic    quat_valid,
    input  logic    gyro_valid,
    input  sample_t quat_w,
    input  sample_t quat_x,
    input  sample_t quat_y,
    input  sample_t quat_z,
    input  sample_t gyro_x,
    input  sample_t gyro_y,
    input  sample_t gyro_z,
    output sample_t cap_quat_w = '0,
    output sample_t cap_quat_x = '0,
    output sample_t cap_quat_y = '0,
    output sample_t cap_quat_z = '0,
    output sample_t cap_gyro_x = '0,
    output sample_t cap_gyro_y = '0,
    output sample_t cap_gyro_z = '0,
    output logic    sync_initialized,
    output logic    sync_error,
    output logic    quat_latched = 1'b0,
    output logic    gyro_latched = 1'b0,
    output logic    cs_sel
);

    // Synchronizer chains, bit 0 takes the raw input
    logic [`SL_SYNC_STAGES-1:0] init_sync = '0;
    logic [`SL_SYNC_STAGES-1:0] err_sync = '0;

    // Registered copies of the one-cycle valid pulses
    logic quat_valid_q = 1'b0;
    logic gyro_valid_q = 1'b0;

    // Registered chip select, idle high
    logic cs_q = 1'b1;
    logic cs_rise;

    // --------------------------------------------------
    // Input registers and flag synchronizers
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        cap_quat_w <= quat_w;
        cap_quat_x <= quat_x;
        cap_quat_y <= quat_y;
        cap_quat_z <= quat_z;
        cap_gyro_x <= gyro_x;
        cap_gyro_y <= gyro_y;
        cap_gyro_z <= gyro_z;
        // Level flags walk through the chain one stage per clk
        init_sync <= {init_sync[`SL_SYNC_STAGES-2:0], initialized};
        err_sync <= {err_sync[`SL_SYNC_STAGES-2:0], error};
        quat_valid_q <= quat_valid;
        gyro_valid_q <= gyro_valid;
        cs_q <= cs_n;
    end

    assign sync_initialized = init_sync[`SL_SYNC_STAGES-1];
    assign sync_error = err_sync[`SL_SYNC_STAGES-1];

    // Selected as seen by the clk domain, drives the snapshot freeze
    assign cs_sel = ~cs_q;

    // End of a transaction, chip select is high now but was low last clk
    assign cs_rise = cs_n & ~cs_q;

    // --------------------------------------------------
    // Valid-pulse latches
    // --------------------------------------------------

    // A pulse is remembered until the next transaction has ended, so the
    // flags byte reports whether fresh data arrived in between
    always_ff @(posedge clk) begin
        if (cs_rise) begin
            quat_latched <= 1'b0;
            gyro_latched <= 1'b0;
        end else if (cs_q) begin
            // Only idle time may set a latch, a selected bus holds them
            if (quat_valid_q) begin
                quat_latched <= 1'b1;
            end
            if (gyro_valid_q) begin
                gyro_latched <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/spi_link_pkg.sv ====
`include "sensor_link_cfg.svh"

package spi_link_pkg;

    // --------------------------------------------------
    // Packet and shifter types
    // --------------------------------------------------

    // One byte on the wire, sent MSB first
    typedef logic [7:0] byte_t;

    // Whole packet, element 0 is the header and goes out first
    typedef byte_t [`SL_PACKET_BYTES-1:0] packet_t;

    // Byte position in the transaction, 16 and above is the zero tail
    typedef logic [4:0] byte_idx_t;

    // Bit position inside the current byte, 0 is the MSB slot
    typedef logic [2:0] bit_idx_t;

    // Shifter FSM
    // shift_wait waits for the first sck rise after selection
    // shift_active sends packet bytes, shift_tail sends zeros past byte 15
    typedef enum logic [1:0] {
        shift_wait,
        shift_active,
        shift_tail
    } shift_state_e;

endpackage

// ==== rtl/sensor_pkg.sv ====
`include "sensor_link_cfg.svh"

package sensor_pkg;

    // --------------------------------------------------
    // Sensor data types
    // --------------------------------------------------

    // One axis of a quaternion or gyroscope reading, two's complement
    typedef logic signed [`SL_SAMPLE_W-1:0] sample_t;

    // Status flags as they appear in the low nibble of packet byte 15
    // The member order fixes the bit positions, so error is declared first
    // and lands in bit 3 while quat_valid lands in bit 0
    typedef struct packed {
        // Sensor controller reported a fault
        logic error;
        // Sensor finished its start-up sequence
        logic initialized;
        // A gyroscope sample arrived since the last transaction ended
        logic gyro_valid;
        // A quaternion sample arrived since the last transaction ended
        logic quat_valid;
    } status_flags_t;

endpackage

// ==== rtl/sensor_link_cfg.svh ====
`ifndef SENSOR_LINK_CFG_SVH
`define SENSOR_LINK_CFG_SVH

// --------------------------------------------------
// Packet framing
// --------------------------------------------------

// Bytes in one packet, counting the header and the flags byte
`define SL_PACKET_BYTES 16

// First byte of every packet, used by the master to find the frame start
`define SL_HEADER_BYTE 8'hAA

// --------------------------------------------------
// Sensor side
// --------------------------------------------------

// Width of one signed sensor axis value
`define SL_SAMPLE_W 16

// Flop depth of the level-flag synchronizers in the clk domain
`define SL_SYNC_STAGES 2

`endif
